/* rob_pkg.sv */
package rob_pkg;

    // reorder buffer geometry
    localparam int ROB_DEPTH = 32;
    localparam int ROB_IDX_W = 5;

    // occupancy counter needs one extra state for full
    localparam int COUNT_W = $clog2(ROB_DEPTH + 1);

    // datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 2 ** REG_ADDR_W;

    // byte step between sequential instructions
    localparam int INSN_BYTES = 4;

    // width of the retired instruction counter
    localparam int RETIRE_CNT_W = 32;

    // result lanes: alu, mul, mem, branch
    localparam int CDB_LANES   = 4;
    localparam int CDB_ALU_LANE = 0;
    localparam int CDB_MUL_LANE = 1;
    localparam int CDB_MEM_LANE = 2;
    localparam int CDB_BR_LANE  = 3;

    // entry life cycle
    //   empty    slot is free
    //   rob_wait dispatched, result still pending
    //   done     result written, ready to retire
    typedef enum logic [1:0] {
        empty    = 2'b00,
        rob_wait = 2'b01,
        done     = 2'b10
    } rob_status_t;

    // lane numbering must agree with the lane count
    localparam bit LANES_OK = (CDB_ALU_LANE < CDB_LANES) &&
                              (CDB_MUL_LANE < CDB_LANES) &&
                              (CDB_MEM_LANE < CDB_LANES) &&
                              (CDB_BR_LANE  < CDB_LANES);

    // index width must cover the whole buffer exactly
    localparam bit IDX_OK = (2 ** ROB_IDX_W) == ROB_DEPTH;

endpackage

/* rob.sv */
`timescale 1ns/1ps

module rob
    import rob_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    // dispatch, in program order
    input  logic                                dispatch_valid_i,
    input  logic [XLEN-1:0]                     dispatch_pc_i,
    input  logic [REG_ADDR_W-1:0]               dispatch_rd_i,
    input  logic                                dispatch_regf_we_i,
    input  logic                                dispatch_is_branch_i,
    input  logic                                dispatch_pred_taken_i,
    output logic                                dispatch_ready_o,
    output logic [ROB_IDX_W-1:0]                dispatch_idx_o,
    // common data bus
    input  logic [CDB_LANES-1:0]                cdb_valid_i,
    input  logic [CDB_LANES-1:0][ROB_IDX_W-1:0] cdb_rob_idx_i,
    input  logic [CDB_LANES-1:0][XLEN-1:0]      cdb_data_i,
    input  logic                                cdb_br_taken_i,
    input  logic [XLEN-1:0]                     cdb_br_target_i,
    // commit control
    input  logic                                retire_i,
    input  logic                                flush_i,
    // head view
    output logic                                head_valid_o,
    output rob_status_t                         head_status_o,
    output logic [XLEN-1:0]                     head_pc_o,
    output logic [REG_ADDR_W-1:0]               head_rd_o,
    output logic                                head_regf_we_o,
    output logic [XLEN-1:0]                     head_data_o,
    output logic                                head_is_branch_o,
    output logic                                head_pred_taken_o,
    output logic                                head_br_taken_o,
    output logic [XLEN-1:0]                     head_br_target_o
);

    // control state
    logic [ROB_DEPTH-1:0]  valid_q;
    rob_status_t           status_q [ROB_DEPTH];
    logic [ROB_IDX_W-1:0]  head_q;
    logic [ROB_IDX_W-1:0]  tail_q;
    logic [COUNT_W-1:0]    count_q;

    // entry payload
    logic [XLEN-1:0]       pc_mem         [ROB_DEPTH];
    logic [REG_ADDR_W-1:0] rd_mem         [ROB_DEPTH];
    logic                  regf_we_mem    [ROB_DEPTH];
    logic [XLEN-1:0]       data_mem       [ROB_DEPTH];
    logic                  is_branch_mem  [ROB_DEPTH];
    logic                  pred_taken_mem [ROB_DEPTH];
    logic                  br_taken_mem   [ROB_DEPTH];
    logic [XLEN-1:0]       br_target_mem  [ROB_DEPTH];

    logic                  full;
    logic                  insert;
    logic [CDB_LANES-1:0]  cdb_hit;

    assign full             = (count_q == COUNT_W'(ROB_DEPTH));
    // a retiring head frees a slot in the same cycle
    assign dispatch_ready_o = !full || retire_i;
    // a dispatch in the flush cycle is wrong-path and gets squashed
    assign insert           = dispatch_valid_i && dispatch_ready_o && !flush_i;
    assign dispatch_idx_o   = tail_q;

    // lane matches a waiting entry by index only
    always_comb begin
        for (int l = 0; l < CDB_LANES; l++) begin
            cdb_hit[l] = cdb_valid_i[l] && valid_q[cdb_rob_idx_i[l]] &&
                         (status_q[cdb_rob_idx_i[l]] == rob_wait);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            valid_q <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                status_q[i] <= empty;
            end
        end else if (flush_i) begin
            // head retires, everything younger is dropped
            head_q  <= head_q + 1'b1;
            tail_q  <= head_q + 1'b1;
            count_q <= '0;
            valid_q <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                status_q[i] <= empty;
            end
        end else begin
            for (int l = 0; l < CDB_LANES; l++) begin
                if (cdb_hit[l]) begin
                    status_q[cdb_rob_idx_i[l]] <= done;
                end
            end
            if (retire_i) begin
                valid_q[head_q]  <= 1'b0;
                status_q[head_q] <= empty;
                head_q           <= head_q + 1'b1;
            end
            // tail equals head only when full, and then the head retires first
            if (insert) begin
                valid_q[tail_q]  <= 1'b1;
                status_q[tail_q] <= rob_wait;
                tail_q           <= tail_q + 1'b1;
            end
            case ({insert, retire_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (insert) begin
            pc_mem[tail_q]         <= dispatch_pc_i;
            rd_mem[tail_q]         <= dispatch_rd_i;
            regf_we_mem[tail_q]    <= dispatch_regf_we_i;
            is_branch_mem[tail_q]  <= dispatch_is_branch_i;
            pred_taken_mem[tail_q] <= dispatch_pred_taken_i;
        end
        for (int l = 0; l < CDB_LANES; l++) begin
            if (cdb_hit[l] && !flush_i) begin
                data_mem[cdb_rob_idx_i[l]] <= cdb_data_i[l];
            end
        end
        // branch outcome only on its own lane
        if (cdb_hit[CDB_BR_LANE] && !flush_i) begin
            br_taken_mem[cdb_rob_idx_i[CDB_BR_LANE]]  <= cdb_br_taken_i;
            br_target_mem[cdb_rob_idx_i[CDB_BR_LANE]] <= cdb_br_target_i;
        end
    end

    assign head_valid_o      = valid_q[head_q];
    assign head_status_o     = status_q[head_q];
    assign head_pc_o         = pc_mem[head_q];
    assign head_rd_o         = rd_mem[head_q];
    assign head_regf_we_o    = regf_we_mem[head_q];
    assign head_data_o       = data_mem[head_q];
    assign head_is_branch_o  = is_branch_mem[head_q];
    assign head_pred_taken_o = pred_taken_mem[head_q];
    assign head_br_taken_o   = br_taken_mem[head_q];
    assign head_br_target_o  = br_target_mem[head_q];

    // results must name an in-flight entry
    for (genvar l = 0; l < CDB_LANES; l++) begin : g_cdb_chk
        a_cdb_names_valid: assert property (@(posedge clk) disable iff (rst)
            cdb_valid_i[l] |-> valid_q[cdb_rob_idx_i[l]]);
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count_q <= COUNT_W'(ROB_DEPTH));

    // commit only flushes while retiring a branch
    a_flush_with_retire: assert property (@(posedge clk) disable iff (rst)
        flush_i |-> retire_i);

endmodule

/* commit_unit.sv */
`timescale 1ns/1ps

module commit_unit
    import rob_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    // head entry of the rob
    input  logic                    head_valid_i,
    input  rob_status_t             head_status_i,
    input  logic [XLEN-1:0]         head_pc_i,
    input  logic [REG_ADDR_W-1:0]   head_rd_i,
    input  logic                    head_regf_we_i,
    input  logic [XLEN-1:0]         head_data_i,
    input  logic                    head_is_branch_i,
    input  logic                    head_pred_taken_i,
    input  logic                    head_br_taken_i,
    input  logic [XLEN-1:0]         head_br_target_i,
    // rob control
    output logic                    retire_o,
    output logic                    flush_o,
    output logic [XLEN-1:0]         redirect_pc_o,
    // architectural register write
    output logic                    rf_we_o,
    output logic [REG_ADDR_W-1:0]   rf_waddr_o,
    output logic [XLEN-1:0]         rf_wdata_o,
    // statistics
    output logic [RETIRE_CNT_W-1:0] retired_count_o
);

    logic                    mispredict;
    logic                    writes_reg;
    logic [RETIRE_CNT_W-1:0] retired_q;

    // one entry per cycle, head only
    assign retire_o = head_valid_i && (head_status_i == done);

    // direction mismatch against the prediction made at fetch
    assign mispredict = head_is_branch_i && (head_br_taken_i != head_pred_taken_i);
    assign flush_o    = retire_o && mispredict;

    // correct path after the branch
    always_comb begin
        if (head_br_taken_i) begin
            redirect_pc_o = head_br_target_i;
        end else begin
            redirect_pc_o = head_pc_i + XLEN'(INSN_BYTES);
        end
    end

    // x0 and non-writing instructions leave state alone
    assign writes_reg = head_regf_we_i && (head_rd_i != '0);
    assign rf_we_o    = retire_o && writes_reg;
    assign rf_waddr_o = head_rd_i;
    assign rf_wdata_o = head_data_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            retired_q <= '0;
        end else if (retire_o) begin
            retired_q <= retired_q + 1'b1;
        end
    end

    assign retired_count_o = retired_q;

    // head valid bit and head status always agree
    a_head_consistent: assert property (@(posedge clk) disable iff (rst)
        head_valid_i == (head_status_i != empty));

endmodule

/* arch_regfile.sv */
`timescale 1ns/1ps

module arch_regfile
    import rob_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // write port, driven at commit
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    // read port
    input  logic [REG_ADDR_W-1:0] raddr_i,
    output logic [XLEN-1:0]       rdata_o
);

    logic [XLEN-1:0] regs_q [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            // x0 is hardwired, so its writes are dropped
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // combinational read, no bypass of the same-cycle write
    assign rdata_o = regs_q[raddr_i];

endmodule

/* rob_backend_top.sv */
`timescale 1ns/1ps

module rob_backend_top
    import rob_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst,
    // dispatch
    input  logic                                dispatch_valid_i,
    input  logic [XLEN-1:0]                     dispatch_pc_i,
    input  logic [REG_ADDR_W-1:0]               dispatch_rd_i,
    input  logic                                dispatch_regf_we_i,
    input  logic                                dispatch_is_branch_i,
    input  logic                                dispatch_pred_taken_i,
    output logic                                dispatch_ready_o,
    output logic [ROB_IDX_W-1:0]                dispatch_idx_o,
    // common data bus
    input  logic [CDB_LANES-1:0]                cdb_valid_i,
    input  logic [CDB_LANES-1:0][ROB_IDX_W-1:0] cdb_rob_idx_i,
    input  logic [CDB_LANES-1:0][XLEN-1:0]      cdb_data_i,
    input  logic                                cdb_br_taken_i,
    input  logic [XLEN-1:0]                     cdb_br_target_i,
    // retirement
    output logic                                retire_valid_o,
    output logic [XLEN-1:0]                     retire_pc_o,
    output logic [REG_ADDR_W-1:0]               retire_rd_o,
    output logic [XLEN-1:0]                     retire_data_o,
    output logic                                flush_o,
    output logic [XLEN-1:0]                     redirect_pc_o,
    output logic [RETIRE_CNT_W-1:0]             retired_count_o,
    // register file read
    input  logic [REG_ADDR_W-1:0]               rf_raddr_i,
    output logic [XLEN-1:0]                     rf_rdata_o
);

    logic                  head_valid;
    rob_status_t           head_status;
    logic [XLEN-1:0]       head_pc;
    logic [REG_ADDR_W-1:0] head_rd;
    logic                  head_regf_we;
    logic [XLEN-1:0]       head_data;
    logic                  head_is_branch;
    logic                  head_pred_taken;
    logic                  head_br_taken;
    logic [XLEN-1:0]       head_br_target;

    logic                  retire;
    logic                  flush;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [XLEN-1:0]       rf_wdata;

    rob u_rob (
        .clk                   (clk),
        .rst                   (rst),
        .dispatch_valid_i      (dispatch_valid_i),
        .dispatch_pc_i         (dispatch_pc_i),
        .dispatch_rd_i         (dispatch_rd_i),
        .dispatch_regf_we_i    (dispatch_regf_we_i),
        .dispatch_is_branch_i  (dispatch_is_branch_i),
        .dispatch_pred_taken_i (dispatch_pred_taken_i),
        .dispatch_ready_o      (dispatch_ready_o),
        .dispatch_idx_o        (dispatch_idx_o),
        .cdb_valid_i           (cdb_valid_i),
        .cdb_rob_idx_i         (cdb_rob_idx_i),
        .cdb_data_i            (cdb_data_i),
        .cdb_br_taken_i        (cdb_br_taken_i),
        .cdb_br_target_i       (cdb_br_target_i),
        .retire_i              (retire),
        .flush_i               (flush),
        .head_valid_o          (head_valid),
        .head_status_o         (head_status),
        .head_pc_o             (head_pc),
        .head_rd_o             (head_rd),
        .head_regf_we_o        (head_regf_we),
        .head_data_o           (head_data),
        .head_is_branch_o      (head_is_branch),
        .head_pred_taken_o     (head_pred_taken),
        .head_br_taken_o       (head_br_taken),
        .head_br_target_o      (head_br_target)
    );

    commit_unit u_commit_unit (
        .clk               (clk),
        .rst               (rst),
        .head_valid_i      (head_valid),
        .head_status_i     (head_status),
        .head_pc_i         (head_pc),
        .head_rd_i         (head_rd),
        .head_regf_we_i    (head_regf_we),
        .head_data_i       (head_data),
        .head_is_branch_i  (head_is_branch),
        .head_pred_taken_i (head_pred_taken),
        .head_br_taken_i   (head_br_taken),
        .head_br_target_i  (head_br_target),
        .retire_o          (retire),
        .flush_o           (flush),
        .redirect_pc_o     (redirect_pc_o),
        .rf_we_o           (rf_we),
        .rf_waddr_o        (rf_waddr),
        .rf_wdata_o        (rf_wdata),
        .retired_count_o   (retired_count_o)
    );

    arch_regfile u_arch_regfile (
        .clk     (clk),
        .rst     (rst),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (rf_raddr_i),
        .rdata_o (rf_rdata_o)
    );

    // retirement view straight from the head entry
    assign retire_valid_o = retire;
    assign retire_pc_o    = head_pc;
    assign retire_rd_o    = head_rd;
    assign retire_data_o  = head_data;
    assign flush_o        = flush;

endmodule

/* tb_rob_backend.sv */
`timescale 1ns/1ps

module tb_rob_backend
    import rob_pkg::*;
();

    localparam int RANDOM_CYCLES = 200;
    // about 700 cycles of tests and register sweeps, padded for slow random drains
    localparam int TIMEOUT_CYCLES = 3000;

    logic                                clk;
    logic                                rst;
    logic                                dispatch_valid_i;
    logic [XLEN-1:0]                     dispatch_pc_i;
    logic [REG_ADDR_W-1:0]               dispatch_rd_i;
    logic                                dispatch_regf_we_i;
    logic                                dispatch_is_branch_i;
    logic                                dispatch_pred_taken_i;
    logic                                dispatch_ready_o;
    logic [ROB_IDX_W-1:0]                dispatch_idx_o;
    logic [CDB_LANES-1:0]                cdb_valid_i;
    logic [CDB_LANES-1:0][ROB_IDX_W-1:0] cdb_rob_idx_i;
    logic [CDB_LANES-1:0][XLEN-1:0]      cdb_data_i;
    logic                                cdb_br_taken_i;
    logic [XLEN-1:0]                     cdb_br_target_i;
    logic                                retire_valid_o;
    logic [XLEN-1:0]                     retire_pc_o;
    logic [REG_ADDR_W-1:0]               retire_rd_o;
    logic [XLEN-1:0]                     retire_data_o;
    logic                                flush_o;
    logic [XLEN-1:0]                     redirect_pc_o;
    logic [RETIRE_CNT_W-1:0]             retired_count_o;
    logic [REG_ADDR_W-1:0]               rf_raddr_i;
    logic [XLEN-1:0]                     rf_rdata_o;

    // reference model, indexed by rob slot, program order kept in order_q
    logic [XLEN-1:0]       m_pc     [ROB_DEPTH];
    logic [REG_ADDR_W-1:0] m_rd     [ROB_DEPTH];
    logic                  m_we     [ROB_DEPTH];
    logic                  m_br     [ROB_DEPTH];
    logic                  m_pred   [ROB_DEPTH];
    logic                  m_done   [ROB_DEPTH];
    logic                  m_taken  [ROB_DEPTH];
    logic [XLEN-1:0]       m_data   [ROB_DEPTH];
    logic [XLEN-1:0]       m_target [ROB_DEPTH];
    logic [XLEN-1:0]       m_regs   [NUM_REGS];
    logic [ROB_IDX_W-1:0]  order_q  [$];
    logic [ROB_IDX_W-1:0]  m_tail;
    logic [31:0]           lfsr;
    int                    retired_n;
    int                    flush_n;
    int                    errors;
    int                    tests_run;
    int                    tests_failed;
    int                    cycle_cnt;

    rob_backend_top u_rob_backend_top (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("ERROR: timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], rand_bit()};
        end
        return val;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("ERROR: %s got %h expected %h", name, got, exp);
        errors++;
    endtask

    // predicts this cycle at the falling edge, state then matches the next rising edge
    task automatic check_cycle();
        logic                 exp_retire;
        logic                 exp_ready;
        logic                 mispredict;
        logic                 flushed;
        logic [ROB_IDX_W-1:0] h;
        logic [XLEN-1:0]      exp_redirect;
        exp_retire = 1'b0;
        flushed = 1'b0;
        if (order_q.size() > 0) begin
            exp_retire = m_done[order_q[0]];
        end
        exp_ready = (order_q.size() < ROB_DEPTH) || exp_retire;
        if (retire_valid_o !== exp_retire) begin
            report_mismatch("retire_valid_o", 32'(retire_valid_o), 32'(exp_retire));
        end
        if (dispatch_ready_o !== exp_ready) begin
            report_mismatch("dispatch_ready_o", 32'(dispatch_ready_o), 32'(exp_ready));
        end
        if (dispatch_idx_o !== m_tail) begin
            report_mismatch("dispatch_idx_o", 32'(dispatch_idx_o), 32'(m_tail));
        end
        if (retired_count_o !== retired_n) begin
            report_mismatch("retired_count_o", retired_count_o, 32'(retired_n));
        end
        if (flush_o === 1'b1) begin
            flush_n++;
        end
        if (exp_retire) begin
            h = order_q.pop_front();
            mispredict = m_br[h] && (m_taken[h] != m_pred[h]);
            exp_redirect = m_taken[h] ? m_target[h] : m_pc[h] + 32'd4;
            if (retire_pc_o !== m_pc[h]) begin
                report_mismatch("retire_pc_o", retire_pc_o, m_pc[h]);
            end
            if (retire_rd_o !== m_rd[h]) begin
                report_mismatch("retire_rd_o", 32'(retire_rd_o), 32'(m_rd[h]));
            end
            if (retire_data_o !== m_data[h]) begin
                report_mismatch("retire_data_o", retire_data_o, m_data[h]);
            end
            if (flush_o !== mispredict) begin
                report_mismatch("flush_o", 32'(flush_o), 32'(mispredict));
            end
            if (mispredict && redirect_pc_o !== exp_redirect) begin
                report_mismatch("redirect_pc_o", redirect_pc_o, exp_redirect);
            end
            if (m_we[h] && m_rd[h] != '0) begin
                m_regs[m_rd[h]] = m_data[h];
            end
            retired_n++;
            if (mispredict) begin
                // everything younger than the branch is gone
                order_q.delete();
                m_tail = h + 1'b1;
                flushed = 1'b1;
            end
        end else if (flush_o !== 1'b0) begin
            report_mismatch("flush_o", 32'(flush_o), 32'd0);
        end
        if (!flushed) begin
            for (int l = 0; l < CDB_LANES; l++) begin
                if (cdb_valid_i[l]) begin
                    m_done[cdb_rob_idx_i[l]] = 1'b1;
                    m_data[cdb_rob_idx_i[l]] = cdb_data_i[l];
                    if (l == CDB_BR_LANE) begin
                        m_taken[cdb_rob_idx_i[l]] = cdb_br_taken_i;
                        m_target[cdb_rob_idx_i[l]] = cdb_br_target_i;
                    end
                end
            end
            if (dispatch_valid_i && exp_ready) begin
                m_pc[m_tail] = dispatch_pc_i;
                m_rd[m_tail] = dispatch_rd_i;
                m_we[m_tail] = dispatch_regf_we_i;
                m_br[m_tail] = dispatch_is_branch_i;
                m_pred[m_tail] = dispatch_pred_taken_i;
                m_done[m_tail] = 1'b0;
                order_q.push_back(m_tail);
                m_tail = m_tail + 1'b1;
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            check_cycle();
        end
    end

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic dispatch_one(input logic [XLEN-1:0] pc, input logic [REG_ADDR_W-1:0] rd,
                                input logic we, input logic br, input logic pred);
        dispatch_valid_i = 1'b1;
        dispatch_pc_i = pc;
        dispatch_rd_i = rd;
        dispatch_regf_we_i = we;
        dispatch_is_branch_i = br;
        dispatch_pred_taken_i = pred;
        step();
        dispatch_valid_i = 1'b0;
    endtask

    task automatic set_lane(input int l, input logic [ROB_IDX_W-1:0] idx,
                            input logic [XLEN-1:0] data);
        cdb_valid_i[l] = 1'b1;
        cdb_rob_idx_i[l] = idx;
        cdb_data_i[l] = data;
    endtask

    // pending entries only, branches on their own lane
    task automatic drive_writebacks(input logic eager);
        logic [ROB_IDX_W-1:0] pend_alu [$];
        logic [ROB_IDX_W-1:0] pend_br  [$];
        int                   pick;
        foreach (order_q[i]) begin
            if (!m_done[order_q[i]] && m_br[order_q[i]]) begin
                pend_br.push_back(order_q[i]);
            end else if (!m_done[order_q[i]]) begin
                pend_alu.push_back(order_q[i]);
            end
        end
        for (int l = 0; l < CDB_BR_LANE; l++) begin
            if (pend_alu.size() > 0 && (eager || rand_bit())) begin
                pick = rand_bits(5) % pend_alu.size();
                set_lane(l, pend_alu[pick], rand_bits(32));
                pend_alu.delete(pick);
            end
        end
        if (pend_br.size() > 0 && (eager || rand_bit())) begin
            pick = rand_bits(5) % pend_br.size();
            set_lane(CDB_BR_LANE, pend_br[pick], rand_bits(32));
            cdb_br_taken_i = rand_bit();
            cdb_br_target_i = rand_bits(32) & 32'hffff_fffc;
        end
    endtask

    task automatic complete_all(input logic eager);
        while (order_q.size() > 0) begin
            drive_writebacks(eager);
            step();
            cdb_valid_i = '0;
        end
    endtask

    task automatic compare_regs();
        for (int r = 0; r < NUM_REGS; r++) begin
            rf_raddr_i = 5'(r);
            #10;
            if (rf_rdata_o !== m_regs[r]) begin
                report_mismatch($sformatf("rf_rdata_o x%0d", r), rf_rdata_o, m_regs[r]);
            end
            step();
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests_run++;
        if (errors != err0) begin
            tests_failed++;
        end
        $display("test %s finished with %0d errors", name, errors - err0);
    endtask

    task automatic test_reset_state();
        int err0;
        err0 = errors;
        if (retire_valid_o !== 1'b0) begin
            report_mismatch("retire_valid_o", 32'(retire_valid_o), 32'd0);
        end
        if (flush_o !== 1'b0) begin
            report_mismatch("flush_o", 32'(flush_o), 32'd0);
        end
        if (retired_count_o !== '0) begin
            report_mismatch("retired_count_o", retired_count_o, 32'd0);
        end
        if (dispatch_ready_o !== 1'b1) begin
            report_mismatch("dispatch_ready_o", 32'(dispatch_ready_o), 32'd1);
        end
        if (dispatch_idx_o !== '0) begin
            report_mismatch("dispatch_idx_o", 32'(dispatch_idx_o), 32'd0);
        end
        compare_regs();
        end_test("reset_state", err0);
    endtask

    task automatic test_in_order_retire();
        int err0;
        int cnt0;
        err0 = errors;
        cnt0 = retired_n;
        for (int i = 0; i < 6; i++) begin
            dispatch_one(32'h0000_1000 + 4 * i, 5'(i + 1), 1'b1, 1'b0, 1'b0);
        end
        // shuffled completion, several lanes per cycle
        complete_all(1'b0);
        if (retired_count_o !== cnt0 + 6) begin
            report_mismatch("retired_count_o", retired_count_o, 32'(cnt0 + 6));
        end
        compare_regs();
        end_test("in_order_retire", err0);
    endtask

    task automatic test_full_rob();
        int                   err0;
        int                   accepts;
        logic [ROB_IDX_W-1:0] first_idx;
        logic [ROB_IDX_W-1:0] exp_idx;
        err0 = errors;
        accepts = 0;
        first_idx = m_tail;
        while (dispatch_ready_o && accepts < ROB_DEPTH + 8) begin
            exp_idx = 5'(first_idx + accepts);
            if (dispatch_idx_o !== exp_idx) begin
                report_mismatch("dispatch_idx_o", 32'(dispatch_idx_o), 32'(exp_idx));
            end
            dispatch_one(32'h0000_2000 + 4 * accepts, 5'(accepts % 31 + 1), 1'b1, 1'b0, 1'b0);
            accepts++;
        end
        if (accepts != ROB_DEPTH) begin
            report_mismatch("accepted dispatches", 32'(accepts), 32'(ROB_DEPTH));
        end
        // ignored while full
        dispatch_one(32'h0000_2f00, 5'd1, 1'b1, 1'b0, 1'b0);
        set_lane(CDB_ALU_LANE, order_q[0], rand_bits(32));
        step();
        cdb_valid_i = '0;
        if (dispatch_ready_o !== 1'b1) begin
            report_mismatch("dispatch_ready_o", 32'(dispatch_ready_o), 32'd1);
        end
        complete_all(1'b1);
        compare_regs();
        end_test("full_rob", err0);
    endtask

    task automatic run_mispredict(input logic taken);
        logic [ROB_IDX_W-1:0] alu_idx;
        logic [ROB_IDX_W-1:0] br_idx;
        logic [ROB_IDX_W-1:0] young [3];
        int                   flush0;
        flush0 = flush_n;
        alu_idx = m_tail;
        dispatch_one(32'h0000_3000, 5'd10, 1'b1, 1'b0, 1'b0);
        br_idx = m_tail;
        dispatch_one(32'h0000_3004, 5'd11, 1'b1, 1'b1, !taken);
        for (int i = 0; i < 3; i++) begin
            young[i] = m_tail;
            dispatch_one(32'h0000_3008 + 4 * i, 5'(12 + i), 1'b1, 1'b0, 1'b0);
        end
        // younger results arrive first
        for (int i = 0; i < 3; i++) begin
            set_lane(i, young[i], rand_bits(32));
        end
        step();
        cdb_valid_i = '0;
        set_lane(CDB_BR_LANE, br_idx, rand_bits(32));
        cdb_br_taken_i = taken;
        cdb_br_target_i = 32'h0000_3800;
        step();
        cdb_valid_i = '0;
        set_lane(CDB_ALU_LANE, alu_idx, rand_bits(32));
        step();
        cdb_valid_i = '0;
        complete_all(1'b0);
        if (flush_n != flush0 + 1) begin
            report_mismatch("flush_o pulses", 32'(flush_n - flush0), 32'd1);
        end
        if (dispatch_idx_o !== br_idx + 5'd1) begin
            report_mismatch("dispatch_idx_o", 32'(dispatch_idx_o), 32'(br_idx + 5'd1));
        end
    endtask

    task automatic test_mispredict_flush();
        int err0;
        err0 = errors;
        run_mispredict(1'b1);
        run_mispredict(1'b0);
        compare_regs();
        end_test("mispredict_flush", err0);
    endtask

    task automatic test_write_rules();
        int err0;
        int cnt0;
        err0 = errors;
        cnt0 = retired_n;
        dispatch_one(32'h0000_5000, 5'd0, 1'b1, 1'b0, 1'b0);
        dispatch_one(32'h0000_5004, 5'd5, 1'b0, 1'b0, 1'b0);
        dispatch_one(32'h0000_5008, 5'd6, 1'b1, 1'b0, 1'b0);
        complete_all(1'b1);
        if (retired_count_o !== cnt0 + 3) begin
            report_mismatch("retired_count_o", retired_count_o, 32'(cnt0 + 3));
        end
        compare_regs();
        end_test("write_rules", err0);
    endtask

    task automatic test_random_mix();
        int err0;
        err0 = errors;
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            dispatch_valid_i = rand_bit();
            dispatch_pc_i = 32'h0000_4000 + 4 * c;
            dispatch_rd_i = 5'(rand_bits(5));
            dispatch_regf_we_i = rand_bit();
            dispatch_is_branch_i = (rand_bits(2) == 32'd0);
            dispatch_pred_taken_i = rand_bit();
            drive_writebacks(1'b0);
            step();
            dispatch_valid_i = 1'b0;
            cdb_valid_i = '0;
        end
        complete_all(1'b1);
        compare_regs();
        end_test("random_mix", err0);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        dispatch_valid_i = 1'b0;
        dispatch_pc_i = '0;
        dispatch_rd_i = '0;
        dispatch_regf_we_i = 1'b0;
        dispatch_is_branch_i = 1'b0;
        dispatch_pred_taken_i = 1'b0;
        cdb_valid_i = '0;
        cdb_rob_idx_i = '0;
        cdb_data_i = '0;
        cdb_br_taken_i = 1'b0;
        cdb_br_target_i = '0;
        rf_raddr_i = '0;
        lfsr = 32'h0d19_f492;
        m_tail = '0;
        retired_n = 0;
        flush_n = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        cycle_cnt = 0;
        for (int r = 0; r < NUM_REGS; r++) begin
            m_regs[r] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        test_reset_state();
        test_in_order_retire();
        test_full_rob();
        test_mispredict_flush();
        test_write_rules();
        test_random_mix();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
rob_pkg.sv
rob.sv
commit_unit.sv
arch_regfile.sv
rob_backend_top.sv
tb_rob_backend.sv

/* Makefile */
TOP := tb_rob_backend

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
